// File: hw/oflow_pkg.sv
// shared widths and types of the conflict resolver, imported by every block of the design
package oflow_pkg;

	//----------------------------------------
	// widths
	//----------------------------------------
	localparam int id_w     = 4;                  // object id, 16 ids
	localparam int score_w  = 8;                  // unsigned fixed-point score
	localparam int pe_w     = 3;                  // pe number
	localparam int row_w    = 3;                  // score board row index
	localparam int claims_w = pe_w + row_w + 2;   // room for every candidate
	localparam int num_ids  = 1 << id_w;          // entries in the id table

	//----------------------------------------
	// score board
	//----------------------------------------
	typedef struct packed {
		logic               valid;   // slot holds a candidate
		logic [id_w-1:0]    id;      // claimed object
		logic [score_w-1:0] score;   // match score
	} sb_entry_t;                    // 13 bits

	typedef struct packed {
		sb_entry_t upper;            // first slot, scanned first
		sb_entry_t lower;            // second slot
	} sb_row_t;                      // 26 bits

	//----------------------------------------
	// configuration and results
	//----------------------------------------
	typedef struct packed {
		logic [row_w:0]     rows_used;   // rows scanned per pe
		logic [score_w-1:0] score_thr;   // lowest accepted score
	} cfg_t;

	typedef struct packed {
		logic [id_w-1:0]     id;         // reported object
		logic [pe_w-1:0]     pe;         // winning pe
		logic [claims_w-1:0] claims;     // candidates that claimed the id
		logic                conflict;   // more than one claim
	} result_t;

	// resolver walk: clear, scan (read/upper/lower per row), emit
	typedef enum logic [2:0] {
		idle_st,
		clear_st,
		read_st,
		upper_st,
		lower_st,
		emit_st,
		done_st
	} res_state_t;

endpackage

// File: hw/oflow_score_board.sv
// score board rows of all pes, written from outside and read row by row by the resolver
`timescale 1ns/1ps

module oflow_score_board
	import oflow_pkg::*;
#(
	parameter int num_pe   = 4,
	parameter int max_rows = 6
) (
	input  logic             clk,
	// external write port
	input  logic             sb_we,
	input  logic [pe_w-1:0]  sb_pe,
	input  logic [row_w-1:0] sb_row,
	input  sb_row_t          sb_wdata,
	// resolver read port
	input  logic             rd_en,
	input  logic [pe_w-1:0]  rd_pe,
	input  logic [row_w-1:0] rd_row,
	output sb_row_t          rd_data
);

	localparam int depth  = num_pe * max_rows;       // rows over all pes
	localparam int addr_w = $clog2(depth);

	sb_row_t           mem [depth];                  // row storage, pe major
	logic [addr_w-1:0] wr_addr;
	logic [addr_w-1:0] rd_addr;
	sb_row_t           rd_q;                         // registered read data

	//----------------------------------------
	// flat address = pe * max_rows + row
	//----------------------------------------
	assign wr_addr = addr_w'(sb_pe) * addr_w'(max_rows) + addr_w'(sb_row);
	assign rd_addr = addr_w'(rd_pe) * addr_w'(max_rows) + addr_w'(rd_row);

	always_ff @(posedge clk) begin
		if (sb_we) begin
			mem[wr_addr] <= sb_wdata;   // only while resolver idle
		end
	end

	// one-cycle read, data held until next rd_en
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_q <= mem[rd_addr];
		end
	end

	assign rd_data = rd_q;

endmodule

// File: hw/oflow_conflict_cfg.sv
// register block of the resolver: rows in use, score threshold, start command and conflict status
`timescale 1ns/1ps

module oflow_conflict_cfg
	import oflow_pkg::*;
#(
	parameter int max_rows = 6
) (
	input  logic        clk,
	input  logic        rst,
	// register port
	input  logic        cfg_we,
	input  logic [1:0]  cfg_addr,
	input  logic [15:0] cfg_wdata,
	output logic [15:0] cfg_rdata,
	// resolver side
	output cfg_t        cfg,
	output logic        start,
	input  logic        busy,
	input  logic        done,
	input  logic [7:0]  conf_count
);

	localparam logic [15:0] rows_lim = 16'(max_rows);   // clamp limit

	logic [row_w:0]     rows_used_q;   // addr 0
	logic [score_w-1:0] thr_q;         // addr 1
	logic               start_q;       // addr 2 write, one-cycle pulse
	logic [7:0]         status_q;      // addr 3, conflicts at last done
	logic               wr_ok;

	assign wr_ok = cfg_we && !busy && !start_q;   // config frozen during a pass

	//----------------------------------------
	// write decode
	//----------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rows_used_q <= '0;
			thr_q       <= '0;
			start_q     <= 1'b0;
		end else begin
			start_q <= wr_ok && (cfg_addr == 2'd2);   // start lags write by one
			if (wr_ok && (cfg_addr == 2'd0)) begin
				if (cfg_wdata > rows_lim)
					rows_used_q <= (row_w+1)'(max_rows);   // clamp to board size
				else
					rows_used_q <= cfg_wdata[row_w:0];
			end
			if (wr_ok && (cfg_addr == 2'd1)) begin
				thr_q <= cfg_wdata[score_w-1:0];
			end
		end
	end

	// status capture at end of pass
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			status_q <= '0;
		else if (done)
			status_q <= conf_count;
	end

	//----------------------------------------
	// read-back, combinational
	//----------------------------------------
	always_comb begin
		unique case (cfg_addr)
			2'd0:    cfg_rdata = 16'(rows_used_q);
			2'd1:    cfg_rdata = 16'(thr_q);
			2'd2:    cfg_rdata = {15'd0, busy};   // pass in progress
			default: cfg_rdata = 16'(status_q);
		endcase
	end

	assign cfg   = '{rows_used: rows_used_q, score_thr: thr_q};
	assign start = start_q;

endmodule

// File: hw/oflow_id_table.sv
// per-id claim table of the resolver: claim count, best score and winning pe for each object id
`timescale 1ns/1ps

module oflow_id_table
	import oflow_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	// clear walk
	input  logic                clr,
	// candidate update
	input  logic                upd,
	input  logic [id_w-1:0]     upd_id,
	input  logic [pe_w-1:0]     upd_pe,
	input  logic [score_w-1:0]  upd_score,
	// read-out
	input  logic [id_w-1:0]     tbl_addr,
	output logic [claims_w-1:0] tbl_claims,
	output logic [pe_w-1:0]     tbl_pe
);

	logic [claims_w-1:0] claims_q [num_ids];   // histogram
	logic [score_w-1:0]  score_q  [num_ids];   // best score so far
	logic [pe_w-1:0]     pe_q     [num_ids];   // pe holding best score
	logic                take_new;

	//----------------------------------------
	// best-entry replace rule
	//----------------------------------------
	// strictly greater only, so with pe-ascending scan equal scores keep
	// the lower pe; an empty entry always takes the candidate
	assign take_new = (claims_q[upd_id] == '0) || (upd_score > score_q[upd_id]);

	// claim counts
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < num_ids; i++) begin
				claims_q[i] <= '0;
			end
		end else if (clr) begin
			claims_q[tbl_addr] <= '0;                          // clear walk entry
		end else if (upd) begin
			claims_q[upd_id] <= claims_q[upd_id] + 1'b1;      // one more claim
		end
	end

	// best score and pe
	always_ff @(posedge clk) begin
		if (clr) begin
			score_q[tbl_addr] <= '0;
			pe_q[tbl_addr]    <= '0;
		end else if (upd && take_new) begin
			score_q[upd_id] <= upd_score;
			pe_q[upd_id]    <= upd_pe;
		end
	end

	//----------------------------------------
	// combinational read-out
	//----------------------------------------
	assign tbl_claims = claims_q[tbl_addr];
	assign tbl_pe     = pe_q[tbl_addr];

endmodule

// File: hw/oflow_conflict_resolve.sv
// resolver FSM: clears the id table, scans all score boards into it, then reports each claimed id
`timescale 1ns/1ps

module oflow_conflict_resolve
	import oflow_pkg::*;
#(
	parameter int num_pe = 4
) (
	input  logic                clk,
	input  logic                rst,
	// control
	input  cfg_t                cfg,
	input  logic                start,
	output logic                busy,
	output logic                done,
	output logic [7:0]          conf_count,
	// score board read
	output logic                rd_en,
	output logic [pe_w-1:0]     rd_pe,
	output logic [row_w-1:0]    rd_row,
	input  sb_row_t             rd_data,
	// id table
	output logic                clr,
	output logic                upd,
	output logic [id_w-1:0]     upd_id,
	output logic [pe_w-1:0]     upd_pe,
	output logic [score_w-1:0]  upd_score,
	output logic [id_w-1:0]     tbl_addr,
	input  logic [claims_w-1:0] tbl_claims,
	input  logic [pe_w-1:0]     tbl_pe,
	// results
	output logic                result_valid,
	output result_t             result
);

	localparam logic [pe_w-1:0] last_pe = pe_w'(num_pe - 1);

	res_state_t       state;
	res_state_t       state_nx;
	logic [id_w-1:0]  id_q;       // clear and emit walk
	logic [pe_w-1:0]  pe_q;       // scan position
	logic [row_w-1:0] row_q;
	logic [7:0]       conf_q;     // conflicts this pass
	logic             last_id;
	logic             last_row;
	logic             scan_end;
	logic             no_rows;
	sb_entry_t        slot;       // candidate under test
	logic             slot_ok;

	assign last_id  = (id_q == id_w'(num_ids - 1));
	assign last_row = ({1'b0, row_q} + 1'b1) == cfg.rows_used;
	assign scan_end = last_row && (pe_q == last_pe);
	assign no_rows  = (cfg.rows_used == '0);   // nothing to scan

	//----------------------------------------
	// state register and next state
	//----------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= idle_st;
		else
			state <= state_nx;
	end

	always_comb begin
		state_nx = state;
		unique case (state)
			idle_st:  if (start) state_nx = clear_st;
			clear_st: if (last_id) state_nx = no_rows ? emit_st : read_st;
			read_st:  state_nx = upper_st;                         // data next cycle
			upper_st: state_nx = lower_st;
			lower_st: state_nx = scan_end ? emit_st : read_st;
			emit_st:  if (last_id) state_nx = done_st;
			done_st:  state_nx = idle_st;
			default:  state_nx = idle_st;
		endcase
	end

	//----------------------------------------
	// walk counters
	//----------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			id_q   <= '0;
			pe_q   <= '0;
			row_q  <= '0;
			conf_q <= '0;
		end else begin
			unique case (state)
				idle_st: begin
					id_q   <= '0;
					pe_q   <= '0;
					row_q  <= '0;
					if (start) conf_q <= '0;   // keep last count until restart
				end
				clear_st, emit_st: begin
					id_q <= id_q + 1'b1;       // wraps to 0 after id 15
					if (state == emit_st && tbl_claims > claims_w'(1))
						conf_q <= conf_q + 1'b1;
				end
				lower_st: begin
					if (last_row) begin
						row_q <= '0;
						pe_q  <= pe_q + 1'b1;   // next pe board
					end else begin
						row_q <= row_q + 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	//----------------------------------------
	// candidate filter
	//----------------------------------------
	assign slot    = (state == upper_st) ? rd_data.upper : rd_data.lower;
	assign slot_ok = slot.valid && (slot.score >= cfg.score_thr);   // threshold inclusive

	// outputs decoded from state
	assign busy   = (state != idle_st);
	assign done   = (state == done_st);
	assign rd_en  = (state == read_st);
	assign rd_pe  = pe_q;
	assign rd_row = row_q;
	assign clr    = (state == clear_st);
	assign upd    = ((state == upper_st) || (state == lower_st)) && slot_ok;

	assign upd_id    = slot.id;
	assign upd_pe    = pe_q;
	assign upd_score = slot.score;
	assign tbl_addr  = id_q;

	assign result_valid    = (state == emit_st) && (tbl_claims != '0);   // claimed ids only
	assign result.id       = id_q;
	assign result.pe       = tbl_pe;
	assign result.claims   = tbl_claims;
	assign result.conflict = (tbl_claims > claims_w'(1));

	assign conf_count = conf_q;   // final at done

endmodule

// File: hw/oflow_conflict_top.sv
// conflict-resolution stage top: score board, register block, id table and resolver FSM
`timescale 1ns/1ps

module oflow_conflict_top
	import oflow_pkg::*;
#(
	parameter int num_pe   = 4,
	parameter int max_rows = 6
) (
	input  logic             clk,
	input  logic             rst,
	// score board write
	input  logic             sb_we,
	input  logic [pe_w-1:0]  sb_pe,
	input  logic [row_w-1:0] sb_row,
	input  sb_row_t          sb_wdata,
	// register port
	input  logic             cfg_we,
	input  logic [1:0]       cfg_addr,
	input  logic [15:0]      cfg_wdata,
	output logic [15:0]      cfg_rdata,
	// status and results
	output logic             busy,
	output logic             done,
	output logic             result_valid,
	output result_t          result
);

	cfg_t                cfg;
	logic                start;
	logic [7:0]          conf_count;
	logic                rd_en;
	logic [pe_w-1:0]     rd_pe;
	logic [row_w-1:0]    rd_row;
	sb_row_t             rd_data;
	logic                clr;
	logic                upd;
	logic [id_w-1:0]     upd_id;
	logic [pe_w-1:0]     upd_pe;
	logic [score_w-1:0]  upd_score;
	logic [id_w-1:0]     tbl_addr;
	logic [claims_w-1:0] tbl_claims;
	logic [pe_w-1:0]     tbl_pe;

	//----------------------------------------
	// blocks
	//----------------------------------------
	oflow_score_board #(.num_pe(num_pe), .max_rows(max_rows)) u_sb (
		.clk, .sb_we, .sb_pe, .sb_row, .sb_wdata,
		.rd_en, .rd_pe, .rd_row, .rd_data
	);

	oflow_conflict_cfg #(.max_rows(max_rows)) u_cfg (
		.clk, .rst, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
		.cfg, .start, .busy, .done, .conf_count
	);

	oflow_id_table u_tbl (
		.clk, .rst, .clr, .upd, .upd_id, .upd_pe, .upd_score,
		.tbl_addr, .tbl_claims, .tbl_pe
	);

	oflow_conflict_resolve #(.num_pe(num_pe)) u_res (
		.clk, .rst, .cfg, .start, .busy, .done, .conf_count,
		.rd_en, .rd_pe, .rd_row, .rd_data,
		.clr, .upd, .upd_id, .upd_pe, .upd_score,
		.tbl_addr, .tbl_claims, .tbl_pe,
		.result_valid, .result
	);

endmodule

// File: testbench/oflow_checker.sv
// result checker that compares result beats, result count and conflict status with the expected list
`timescale 1ns/1ps

module oflow_checker
	import oflow_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        result_valid,
	input  result_t     result,
	input  logic        done,
	input  logic [15:0] cfg_rdata,    // parked on address 3
	input  string       test_name,
	input  result_t     exp_list [num_ids],
	input  int          exp_n,
	input  logic [7:0]  exp_conf,
	output int          errors
);

	int   idx;          // next expected beat
	logic status_due;   // status register valid one cycle after done

	// sampled on the falling edge once DUT outputs have settled
	always @(negedge clk or posedge rst) begin : compare
		int n;
		n = 0;
		if (rst) begin
			idx        <= 0;
			errors     <= 0;
			status_due <= 1'b0;
		end else begin
			status_due <= done;
			if (result_valid) begin
				if (idx >= exp_n) begin
					$display("Error %s: extra result for id %0d, expected %0d results",
						test_name, result.id, exp_n);
					n++;
				end else if (result !== exp_list[idx]) begin
					$write("Error %s: result %0d expected id %0d pe %0d claims %0d conflict %0d",
						test_name, idx, exp_list[idx].id, exp_list[idx].pe,
						exp_list[idx].claims, exp_list[idx].conflict);
					$display(", actual id %0d pe %0d claims %0d conflict %0d",
						result.id, result.pe, result.claims, result.conflict);
					n++;
				end
				idx <= idx + 1;
			end
			if (done) begin
				if (idx != exp_n) begin
					$display("Error %s: result count expected %0d actual %0d",
						test_name, exp_n, idx);
					n++;
				end
				idx <= 0;   // ready for next pass
			end
			if (status_due && cfg_rdata[7:0] !== exp_conf) begin
				$display("Error %s: conflict count expected %0d actual %0d",
					test_name, exp_conf, cfg_rdata[7:0]);
				n++;
			end
			errors <= errors + n;
		end
	end

endmodule

// File: testbench/oflow_conflict_assert.sv
// assertions bound to the resolver FSM: done width, no results while idle, updates only in slot states
`timescale 1ns/1ps

module oflow_conflict_assert
	import oflow_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input res_state_t state,
	input logic       done,
	input logic       result_valid,
	input logic       upd
);

	int fails = 0;

	done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else begin
			$error("done stayed high for more than one cycle");
			fails++;
		end

	idle_quiet: assert property (@(posedge clk) disable iff (rst)
		(state == idle_st) |-> !result_valid)
		else begin
			$error("result_valid seen while the resolver was idle");
			fails++;
		end

	upd_in_scan: assert property (@(posedge clk) disable iff (rst)
		upd |-> (state inside {upper_st, lower_st}))
		else begin
			$error("id table update outside the slot states");
			fails++;
		end

endmodule

bind oflow_conflict_resolve oflow_conflict_assert u_assert (
	.clk, .rst, .state, .done, .result_valid, .upd
);

// File: testbench/oflow_tb.sv
// testbench top for the conflict resolver: drives score boards and registers, runs passes, sums up
`timescale 1ns/1ps

module oflow_tb
	import oflow_pkg::*;
();

	localparam int num_pe     = 4;
	localparam int max_rows   = 6;
	localparam int done_limit = 1000;   // cycles, well above the longest pass

	logic             clk;
	logic             rst;
	logic             sb_we;
	logic [pe_w-1:0]  sb_pe;
	logic [row_w-1:0] sb_row;
	sb_row_t          sb_wdata;
	logic             cfg_we;
	logic [1:0]       cfg_addr;
	logic [15:0]      cfg_wdata;
	logic [15:0]      cfg_rdata;
	logic             busy;
	logic             done;
	logic             result_valid;
	result_t          result;

	sb_row_t    model [num_pe][max_rows];   // mirror of the score boards
	result_t    exp_list [num_ids];         // expected beats, ascending id
	int         exp_n;
	logic [7:0] exp_conf;
	string      test_name;
	int         chk_errors;                 // from the checker
	int         tb_errors;
	int         asrt_fails;
	int         n_tests;
	int         n_failed;
	integer     seed;

	oflow_conflict_top #(.num_pe(num_pe), .max_rows(max_rows)) u_dut (
		.clk, .rst, .sb_we, .sb_pe, .sb_row, .sb_wdata,
		.cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
		.busy, .done, .result_valid, .result
	);

	oflow_checker u_chk (
		.clk, .rst, .result_valid, .result, .done, .cfg_rdata,
		.test_name, .exp_list, .exp_n, .exp_conf, .errors(chk_errors)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // 8 ns period
	end

	//----------------------------------------
	// reference model
	//----------------------------------------
	function automatic void build_expected(input int rows, input int thr);
		int        claims [num_ids];
		int        best_score [num_ids];
		int        best_pe [num_ids];
		int        n_rows;
		sb_entry_t cand [2];
		n_rows = (rows > max_rows) ? max_rows : rows;   // register clamps
		for (int i = 0; i < num_ids; i++) begin
			claims[i]     = 0;
			best_score[i] = 0;
			best_pe[i]    = 0;
		end
		for (int p = 0; p < num_pe; p++) begin          // pe ascending
			for (int r = 0; r < n_rows; r++) begin
				cand[0] = model[p][r].upper;
				cand[1] = model[p][r].lower;
				foreach (cand[s]) begin
					int id;
					id = int'(cand[s].id);
					if (cand[s].valid && int'(cand[s].score) >= thr) begin
						if (claims[id] == 0 || int'(cand[s].score) > best_score[id]) begin
							best_score[id] = int'(cand[s].score);   // strictly greater wins
							best_pe[id]    = p;
						end
						claims[id]++;
					end
				end
			end
		end
		exp_n    = 0;
		exp_conf = '0;
		for (int i = 0; i < num_ids; i++) begin
			if (claims[i] > 0) begin
				exp_list[exp_n] = '{id: id_w'(i), pe: pe_w'(best_pe[i]),
					claims: claims_w'(claims[i]), conflict: (claims[i] > 1)};
				if (claims[i] > 1)
					exp_conf = exp_conf + 8'd1;
				exp_n++;
			end
		end
	endfunction

	function automatic sb_entry_t entry(input bit v, input int id, input int score);
		return '{valid: v, id: id_w'(id), score: score_w'(score)};
	endfunction

	function automatic sb_entry_t rand_entry();
		logic [31:0] r;
		r = $random(seed);
		return '{valid: (r[17:16] != 2'b00), id: r[3:0], score: r[15:8]};   // 3/4 valid
	endfunction

	//----------------------------------------
	// stimulus
	//----------------------------------------
	task automatic load_row(input int pe, input int row, input sb_row_t data);
		@(posedge clk);
		#1;
		sb_we    = 1'b1;
		sb_pe    = pe_w'(pe);
		sb_row   = row_w'(row);
		sb_wdata = data;
		model[pe][row] = data;
		@(posedge clk);
		#1;
		sb_we = 1'b0;
	endtask

	task automatic write_reg(input logic [1:0] addr, input int data);
		@(posedge clk);
		#1;
		cfg_we    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = 16'(data);
		@(posedge clk);
		#1;
		cfg_we   = 1'b0;
		cfg_addr = 2'd3;   // park on conflict status
	endtask

	task automatic clear_boards();
		for (int p = 0; p < num_pe; p++)
			for (int r = 0; r < max_rows; r++)
				load_row(p, r, '0);
	endtask

	task automatic fill_random();
		for (int p = 0; p < num_pe; p++)
			for (int r = 0; r < max_rows; r++)
				load_row(p, r, '{upper: rand_entry(), lower: rand_entry()});
	endtask

	task automatic wait_for_done();
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < done_limit && !seen; i++) begin
			@(negedge clk);
			seen = done;
		end
		if (!seen) begin
			$display("done never came in test %s", test_name);
			$display("Simulation finished: FAIL");
			$finish;
		end
	endtask

	// one resolver pass, optionally with a second start while busy
	task automatic run_pass(input string name, input int rows, input int thr,
		input bit poke_start);
		int errs_before;
		int busy_seen;
		test_name = name;
		write_reg(2'd0, rows);
		write_reg(2'd1, thr);
		build_expected(rows, thr);
		errs_before = chk_errors + tb_errors;
		write_reg(2'd2, 0);                 // start
		if (poke_start) begin
			repeat (6) @(posedge clk);
			write_reg(2'd2, 0);             // lands while busy
		end
		wait_for_done();
		busy_seen = 0;
		repeat (4) begin                    // also covers the status compare
			@(negedge clk);
			if (busy)
				busy_seen++;
		end
		if (busy_seen != 0) begin
			$display("busy rose again after done in test %s, a second pass started", name);
			tb_errors++;
		end
		n_tests++;
		if (chk_errors + tb_errors == errs_before) begin
			$display("test %s: ok, %0d results, %0d conflicts", name, exp_n, exp_conf);
		end else begin
			n_failed++;
			$display("test %s: failed", name);
		end
	endtask

	//----------------------------------------
	// test sequence
	//----------------------------------------
	initial begin
		rst        = 1'b1;
		sb_we      = 1'b0;
		sb_pe      = '0;
		sb_row     = '0;
		sb_wdata   = '0;
		cfg_we     = 1'b0;
		cfg_addr   = 2'd3;
		cfg_wdata  = '0;
		exp_n      = 0;
		exp_conf   = '0;
		test_name  = "reset";
		tb_errors  = 0;
		n_tests    = 0;
		n_failed   = 0;
		seed       = 59;
		foreach (exp_list[i])
			exp_list[i] = '0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		clear_boards();                                     // one owner per id
		load_row(0, 0, '{upper: entry(1, 1, 50), lower: '0});
		load_row(1, 0, '{upper: entry(1, 2, 60), lower: '0});
		load_row(2, 1, '{upper: '0, lower: entry(1, 3, 70)});
		load_row(3, 5, '{upper: entry(1, 4, 80), lower: entry(1, 15, 90)});
		run_pass("distinct ids", 6, 10, 1'b0);

		clear_boards();                                     // shared ids
		load_row(0, 0, '{upper: entry(1, 5, 30), lower: '0});
		load_row(1, 3, '{upper: entry(1, 7, 60), lower: entry(1, 5, 90)});
		load_row(3, 0, '{upper: entry(1, 5, 40), lower: '0});
		load_row(2, 1, '{upper: entry(1, 6, 20), lower: entry(1, 6, 25)});
		run_pass("conflicts", 6, 10, 1'b0);

		clear_boards();                                     // ties keep lower pe
		load_row(1, 0, '{upper: entry(1, 9, 77), lower: '0});
		load_row(2, 0, '{upper: '0, lower: entry(1, 9, 50)});
		load_row(3, 0, '{upper: entry(1, 9, 77), lower: '0});
		load_row(0, 2, '{upper: entry(1, 8, 120), lower: entry(1, 8, 120)});
		run_pass("equal scores", 6, 10, 1'b0);

		clear_boards();                                     // threshold and valid bit
		load_row(0, 0, '{upper: entry(1, 10, 39), lower: entry(1, 11, 40)});
		load_row(1, 0, '{upper: entry(0, 12, 200), lower: entry(1, 12, 0)});
		load_row(2, 1, '{upper: entry(0, 13, 255), lower: '0});
		run_pass("threshold", 6, 40, 1'b0);

		clear_boards();                                     // rows beyond rows_used
		load_row(0, 1, '{upper: entry(1, 14, 60), lower: '0});
		load_row(0, 2, '{upper: entry(1, 13, 70), lower: '0});
		load_row(2, 0, '{upper: '0, lower: entry(1, 0, 50)});
		load_row(3, 5, '{upper: '0, lower: entry(1, 0, 99)});
		run_pass("rows used", 2, 10, 1'b0);
		run_pass("rows clamped", 9, 10, 1'b0);

		for (int k = 0; k < 4; k++) begin
			fill_random();
			run_pass($sformatf("random %0d", k), {$random(seed)} % 7,
				{$random(seed)} % 128, (k == 1));
		end

		asrt_fails = u_dut.u_res.u_assert.fails;
		$display("tests %0d, failed %0d, check errors %0d, other errors %0d, assertion errors %0d",
			n_tests, n_failed, chk_errors, tb_errors, asrt_fails);
		if (n_failed == 0 && chk_errors == 0 && tb_errors == 0 && asrt_fails == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: build.f
hw/oflow_pkg.sv
hw/oflow_score_board.sv
hw/oflow_conflict_cfg.sv
hw/oflow_id_table.sv
hw/oflow_conflict_resolve.sv
hw/oflow_conflict_top.sv
testbench/oflow_checker.sv
testbench/oflow_conflict_assert.sv
testbench/oflow_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the conflict resolver testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module oflow_tb -f build.f -o oflow_sim

sim_out=$(./obj_dir/oflow_sim +verilator+error+limit+100 || true)
echo "$sim_out"

if grep -q "Simulation finished: PASS" <<< "$sim_out"; then
	exit 0
fi
exit 1
